// ==== hdl/rvDefines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath width, also used for addresses
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// Default data RAM depth in words
`define MEM_WORDS 64

// Instruction field widths
`define OPCODE_W 7
`define FUNCT3_W 3
`define ALU_OP_W 2
`define ALU_CTRL_W 3
`define IMM_SRC_W 2

`endif

// ==== hdl/rvPkg.sv ====
`include "rvDefines.svh"

package rvPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011
    } opcodeT;

    // Operation class handed from main decoder to ALU decoder
    typedef enum logic [`ALU_OP_W-1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10
    } aluOpT;

    typedef enum logic [`ALU_CTRL_W-1:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluCtrlT;

    typedef enum logic [`IMM_SRC_W-1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10
    } immSrcT;

endpackage

// ==== hdl/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
    input  logic           reset,
    input  rvPkg::opcodeT  op,
    output logic           branch,
    output logic           resultSrc,
    output logic           memWrite,
    output logic           aluSrc,
    output logic           regWrite,
    output rvPkg::immSrcT  immSrc,
    output rvPkg::aluOpT   aluOp
);
    import rvPkg::*;

    logic memWriteRaw;
    logic regWriteRaw;

    always_comb
    begin
        // Defaults form the no-op row for unknown opcodes
        regWriteRaw = 1'b0;
        immSrc      = IMM_I;
        aluSrc      = 1'b0;
        memWriteRaw = 1'b0;
        resultSrc   = 1'b0;
        branch      = 1'b0;
        aluOp       = ALUOP_ADD;
        case (op)
            LOAD:
            begin
                regWriteRaw = 1'b1;
                aluSrc      = 1'b1;
                resultSrc   = 1'b1; // Write back RAM data
            end
            STORE:
            begin
                immSrc      = IMM_S;
                aluSrc      = 1'b1;
                memWriteRaw = 1'b1;
            end
            OP:
            begin
                regWriteRaw = 1'b1;
                aluOp       = ALUOP_FUNCT;
            end
            OPIMM:
            begin
                regWriteRaw = 1'b1;
                aluSrc      = 1'b1;
                aluOp       = ALUOP_FUNCT;
            end
            BRANCH:
            begin
                immSrc      = IMM_B;
                branch      = 1'b1;
                aluOp       = ALUOP_SUB; // Compare by subtraction
            end
            default:
            begin
                regWriteRaw = 1'b0;
            end
        endcase
    end

    // No architectural writes while in reset
    assign memWrite = memWriteRaw & ~reset;
    assign regWrite = regWriteRaw & ~reset;

endmodule

// ==== hdl/aluDecoder.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module aluDecoder (
    input  rvPkg::aluOpT          aluOp,
    input  logic [`FUNCT3_W-1:0]  funct3,
    input  logic                  funct7b5,
    input  logic                  opb5,
    output rvPkg::aluCtrlT        aluCtrl
);
    import rvPkg::*;

    logic isSub;

    // Only R-type with funct7 bit 5 subtracts, addi never does
    assign isSub = funct7b5 & opb5;

    always_comb
    begin
        case (aluOp)
            ALUOP_ADD:
            begin
                aluCtrl = ALU_ADD;
            end
            ALUOP_SUB:
            begin
                aluCtrl = ALU_SUB;
            end
            ALUOP_FUNCT:
            begin
                case (funct3)
                    3'b000:  aluCtrl = isSub ? ALU_SUB : ALU_ADD;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD; // Outside the subset
                endcase
            end
            default:
            begin
                aluCtrl = ALU_ADD;
            end
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module regFile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    writeEnable,
    input  logic [`REG_ADDR_W-1:0]  readAddr1,
    input  logic [`REG_ADDR_W-1:0]  readAddr2,
    input  logic [`REG_ADDR_W-1:0]  writeAddr,
    input  logic [`XLEN-1:0]        writeData,
    output logic [`XLEN-1:0]        readData1,
    output logic [`XLEN-1:0]        readData2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeAddr != '0)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 is hardwired
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== hdl/immExtend.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module immExtend (
    input  logic [31:7]        instr,
    input  rvPkg::immSrcT      immSrc,
    output logic [`XLEN-1:0]   immExt
);
    import rvPkg::*;

    always_comb
    begin
        case (immSrc)
            IMM_I:
                immExt = {{20{instr[31]}}, instr[31:20]};
            IMM_S:
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:
                // Halfword offset, bit 0 always clear
                immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:
                immExt = '0;
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module alu (
    input  logic [`XLEN-1:0]  srcA,
    input  logic [`XLEN-1:0]  srcB,
    input  rvPkg::aluCtrlT    aluCtrl,
    output logic [`XLEN-1:0]  aluResult,
    output logic              zero
);
    import rvPkg::*;

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb
    begin
        case (aluCtrl)
            ALU_ADD:
                aluResult = srcA + srcB;
            ALU_SUB:
                aluResult = srcA - srcB;
            ALU_AND:
                aluResult = srcA & srcB;
            ALU_OR:
                aluResult = srcA | srcB;
            ALU_SLT:
                aluResult = {{(`XLEN-1){1'b0}}, lessThan};
            default:
                aluResult = srcA + srcB;
        endcase
    end

    assign zero = (aluResult == '0); // Drives beq taken test

endmodule

// ==== hdl/pcUnit.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module pcUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              branch,
    input  logic              zero,
    input  logic [`XLEN-1:0]  immExt,
    output logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  pcPlus4
);

    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;
    logic             pcSrc;

    assign pcPlus4  = pc + `XLEN'd4;
    assign pcTarget = pc + immExt;
    assign pcSrc    = branch & zero; // beq taken
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pcNext;
        end
    end

endmodule

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module dataMemory #(
    parameter int depth = `MEM_WORDS
) (
    input  logic              clk,
    input  logic              writeEnable,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  writeData,
    output logic [`XLEN-1:0]  readData
);

    localparam int idxW = $clog2(depth);

    logic [`XLEN-1:0] ram [depth];
    logic [idxW-1:0]  index;

    // Word index, wraps at the memory depth
    assign index = idxW'((addr >> 2) % depth);

    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            ram[index] <= writeData;
        end
    end

    assign readData = ram[index];

endmodule

// ==== hdl/cpuTop.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module cpuTop (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  instr,
    output logic [`XLEN-1:0]  instrAddr,
    output logic              memWrite,
    output logic [`XLEN-1:0]  dataAddr,
    output logic [`XLEN-1:0]  writeData
);
    import rvPkg::*;

    opcodeT           op;
    logic             branch;
    logic             resultSrc;
    logic             aluSrc;
    logic             regWrite;
    immSrcT           immSrc;
    aluOpT            aluOp;
    aluCtrlT          aluCtrl;
    logic [`XLEN-1:0] readData1;
    logic [`XLEN-1:0] readData2;
    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             zero;
    logic [`XLEN-1:0] readData;
    logic [`XLEN-1:0] result;

    assign op = opcodeT'(instr[`OPCODE_W-1:0]);

    mainDecoder mainDecoder_i (
        .reset, .op, .branch, .resultSrc, .memWrite,
        .aluSrc, .regWrite, .immSrc, .aluOp
    );

    aluDecoder aluDecoder_i (
        .aluOp, .funct3(instr[14:12]), .funct7b5(instr[30]),
        .opb5(instr[5]), .aluCtrl
    );

    regFile regFile_i (
        .clk, .reset, .writeEnable(regWrite),
        .readAddr1(instr[19:15]), .readAddr2(instr[24:20]),
        .writeAddr(instr[11:7]), .writeData(result),
        .readData1, .readData2
    );

    immExtend immExtend_i (.instr(instr[31:7]), .immSrc, .immExt);

    assign srcB = aluSrc ? immExt : readData2;

    alu alu_i (.srcA(readData1), .srcB, .aluCtrl, .aluResult, .zero);

    pcUnit pcUnit_i (
        .clk, .reset, .branch, .zero, .immExt,
        .pc(instrAddr),
        .pcPlus4() // Only needed once jal is added
    );

    dataMemory #(.depth(`MEM_WORDS)) dataMemory_i (
        .clk, .writeEnable(memWrite), .addr(aluResult),
        .writeData(readData2), .readData
    );

    assign result    = resultSrc ? readData : aluResult;
    assign dataAddr  = aluResult;
    assign writeData = readData2;

endmodule

// ==== sim/cpuTb_chk.sv ====
`timescale 1ns/1ps

module cpuTb_chk (
    input logic        clk,
    input logic        reset,
    input logic [31:0] instr,
    input logic [31:0] instrAddr,
    input logic        memWrite
);
    import rvPkg::*;

    int          failCount = 0;
    logic [31:0] branchOff;

    // B-format offset of the current instruction
    assign branchOff = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    noStoreInReset: assert property (@(posedge clk) reset |-> !memWrite)
    else
    begin
        failCount++;
        $error("memWrite high while reset is asserted");
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00)
    else
    begin
        failCount++;
        $error("instrAddr is not word aligned");
    end

    pcStep: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (instrAddr == $past(instrAddr) + 32'd4 ||
                           instrAddr == $past(instrAddr) + $past(branchOff)))
    else
    begin
        failCount++;
        $error("instrAddr moved to neither the next word nor the branch target");
    end

    storeOnlyOnSw: assert property (@(posedge clk) disable iff (reset)
        memWrite == (instr[6:0] == STORE))
    else
    begin
        failCount++;
        $error("memWrite does not follow the store opcode");
    end

endmodule

bind cpuTop cpuTb_chk chk_i (.clk, .reset, .instr, .instrAddr, .memWrite);

// ==== sim/cpuTb.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module cpuTb;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;

    logic             clk = 1'b0;
    logic             reset;
    logic [`XLEN-1:0] instr = '0;
    logic [`XLEN-1:0] instrAddr;
    logic             memWrite;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] writeData;

    logic [31:0] rom [256];
    logic [31:0] regModel [32];
    logic [31:0] memModel [64];
    logic [31:0] storeSeen [64];
    logic [31:0] pcModel;
    int          progLen = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          storeCount = 0;

    cpuTop cpuTop_i (.clk, .reset, .instr, .instrAddr, .memWrite, .dataAddr, .writeData);

    always #20 clk = ~clk;

    // Instruction ROM answers the fetch address
    always @(posedge clk)
    begin
        #2;
        instr <= rom[instrAddr[9:2]];
    end

    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
    end

    function automatic logic [31:0] iType(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rType(logic f7b5, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] sType(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    // ISA result for the funct3 values of the subset
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic sub, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [5:0] wordIndex(logic [31:0] addr);
        return addr[7:2]; // 64-word RAM wraps
    endfunction

    task automatic emit(logic [31:0] word);
        rom[8'(progLen)] = word;
        progLen++;
    endtask

    task automatic reportMismatch(string msg);
        errorCount++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    task automatic buildProgram();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] slot;
        slot = 12'd0;
        emit(sType(5'd0, 5'd0, 12'd220)); // Sits at address 0 while reset is high
        for (int i = 0; i < 8; i++)
        begin
            rd  = 5'(1 + $urandom % 15);
            rs1 = 5'($urandom % 16);
            emit(iType(opImm, rd, 3'b000, rs1, 12'($urandom)));
            emit(sType(rd, 5'd0, slot));
            slot = slot + 12'd4;
        end
        for (int i = 0; i < 6; i++)
        begin
            f3  = (i % 3 == 0) ? 3'b111 : ((i % 3 == 1) ? 3'b110 : 3'b010);
            rd  = 5'(1 + $urandom % 15);
            rs1 = 5'(1 + $urandom % 15);
            emit(iType(opImm, rd, f3, rs1, 12'($urandom)));
            emit(sType(rd, 5'd0, slot));
            slot = slot + 12'd4;
        end
        // add, sub, and, or, slt in turn
        for (int i = 0; i < 10; i++)
        begin
            f3  = (i % 5 == 2) ? 3'b111 : ((i % 5 == 3) ? 3'b110 : 3'b000);
            f3  = (i % 5 == 4) ? 3'b010 : f3;
            rd  = 5'(16 + $urandom % 10);
            rs1 = 5'(1 + $urandom % 15);
            rs2 = 5'(1 + $urandom % 15);
            emit(rType(i % 5 == 1, f3, rd, rs1, rs2));
            emit(sType(rd, 5'd0, slot));
            slot = slot + 12'd4;
        end
        emit(sType(rd, 5'd0, 12'd200)); // Round trip through x26
        emit(iType(opLoad, 5'd26, 3'b010, 5'd0, 12'd200));
        emit(sType(5'd26, 5'd0, 12'd204));
        emit(iType(opImm, 5'd27, 3'b000, 5'd0, 12'd5));
        emit(iType(opImm, 5'd28, 3'b000, 5'd0, 12'd5));
        emit(bType(5'd27, 5'd28, 13'd8)); // Taken, skips next
        emit(iType(opImm, 5'd29, 3'b000, 5'd0, 12'd1));
        emit(iType(opImm, 5'd29, 3'b000, 5'd0, 12'd7));
        emit(bType(5'd27, 5'd29, 13'd8)); // Falls through
        emit(sType(5'd29, 5'd0, 12'd212));
        emit(iType(opImm, 5'd0, 3'b000, 5'd0, 12'd123));
        emit(rType(1'b0, 3'b000, 5'd0, 5'd27, 5'd28));
        emit(sType(5'd0, 5'd0, 12'd208));
        emit({25'h0155aa5, 7'b0001011}); // Custom opcode, must act as no-op
        emit(sType(5'd27, 5'd0, 12'd216));
    endtask

    task automatic retireStep();
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] nextPc;
        logic [4:0]  rd;
        word   = rom[pcModel[9:2]];
        a      = regModel[word[19:15]];
        b      = regModel[word[24:20]];
        rd     = word[11:7];
        immI   = {{20{word[31]}}, word[31:20]};
        immS   = {{20{word[31]}}, word[31:25], word[11:7]};
        immB   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        nextPc = pcModel + 32'd4;
        checkCount++;
        assert (instrAddr === pcModel)
        else reportMismatch($sformatf("instrAddr %h, expected %h", instrAddr, pcModel));
        if (word[6:0] == opStore)
        begin
            storeCount++;
            assert (memWrite === 1'b1 && dataAddr === a + immS && writeData === b)
            else reportMismatch($sformatf("store %b %h=%h, expected %h=%h",
                                          memWrite, dataAddr, writeData, a + immS, b));
            memModel[wordIndex(a + immS)]  = b;
            storeSeen[wordIndex(a + immS)] = writeData;
        end
        else
        begin
            assert (memWrite === 1'b0)
            else reportMismatch($sformatf("unexpected store strobe at pc %h", pcModel));
        end
        case (word[6:0])
            opImm:    regModel[rd] = aluRef(word[14:12], 1'b0, a, immI);
            opReg:    regModel[rd] = aluRef(word[14:12], word[30], a, b);
            opLoad:   regModel[rd] = memModel[wordIndex(a + immI)];
            opBranch: nextPc = (a == b) ? pcModel + immB : nextPc;
            default:  ;
        endcase
        regModel[0] = '0;
        pcModel     = nextPc;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            pcModel = '0;
            for (int i = 0; i < 32; i++)
            begin
                regModel[i[4:0]] = '0;
            end
            for (int i = 0; i < 64; i++)
            begin
                storeSeen[i[5:0]] = '0;
            end
            assert (instrAddr === '0 && memWrite === 1'b0)
            else reportMismatch($sformatf("in reset instrAddr %h memWrite %b",
                                          instrAddr, memWrite));
        end
        else
        begin
            retireStep();
        end
    end

    initial
    begin
        logic [31:0] seedValue;
        logic [31:0] endAddr;
        int          waitCycles;
        seedValue = $urandom(32'hcfbb_c304);
        for (int i = 0; i < 256; i++)
        begin
            rom[i[7:0]] = {i[24:0], 7'h7f}; // Undefined opcode everywhere
        end
        buildProgram();
        endAddr = 32'(progLen * 4);
        waitCycles = 0;
        while (reset !== 1'b0 && waitCycles < 40)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (reset !== 1'b0)
        begin
            errorCount++;
            $display("Timeout: reset was never released");
        end
        waitCycles = 0;
        while (instrAddr !== endAddr && waitCycles < 400)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (instrAddr !== endAddr)
        begin
            errorCount++;
            $display("Timeout: program end address %h was never fetched", endAddr);
        end
        repeat (2) @(posedge clk);
        #5;
        assert (storeSeen[50] === storeSeen[51])
        else reportMismatch($sformatf("reloaded word %h differs from stored %h",
                                      storeSeen[51], storeSeen[50]));
        errorCount += cpuTop_i.chk_i.failCount;
        $display("Checks: %0d, stores: %0d, errors: %0d", checkCount, storeCount, errorCount);
        if (errorCount == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/rvPkg.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/regFile.sv
hdl/immExtend.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/dataMemory.sv
hdl/cpuTop.sv
sim/cpuTb_chk.sv
sim/cpuTb.sv

// ==== Makefile ====
SRCS := hdl/rvDefines.svh $(filter-out +%,$(shell cat tb.f))

.PHONY: all run clean

all: run

obj_dir/VcpuTb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module cpuTb -f tb.f

run: obj_dir/VcpuTb
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
